// ==== common/axi_bus_cfg.svh ====
`ifndef AXI_BUS_CFG_SVH
`define AXI_BUS_CFG_SVH

// Bus widths
`define ADDR_WIDTH 16
`define DATA_WIDTH 32
`define ID_BITS    2

// Burst length field, a burst has len+1 beats
`define LEN_BITS   4

// Memory depths in words
`define MEM_DEPTH  64
`define SCR_DEPTH  16

// Outstanding write bursts in the W route queue
`define ROUTE_DEPTH 4

`endif

// ==== common/axi_bus_pkg.sv ====
`include "axi_bus_cfg.svh"

package axi_bus_pkg;

    // High bit is the source (1 = DMA), low bit the destination (1 = scratch)
    typedef enum logic [`ID_BITS-1:0] {
        ID_CPU2MEM = 0,
        ID_CPU2SCR = 1,
        ID_DMA2MEM = 2,
        ID_DMA2SCR = 3
    } bus_id_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2
    } resp_t;

    function automatic logic id_to_scr(bus_id_t id);
        return id[0];
    endfunction

    function automatic logic id_from_dma(bus_id_t id);
        return id[`ID_BITS-1];
    endfunction

endpackage

// ==== source/fifo.sv ====
`timescale 1ns/100ps

module fifo #(
    parameter int DEPTH = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 push,
    input  logic                 pop,
    input  axi_bus_pkg::bus_id_t wdata,
    output axi_bus_pkg::bus_id_t rdata,
    output logic                 full,
    output logic                 empty
);
    import axi_bus_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    bus_id_t          entries [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign rdata   = entries[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            entries[wr_ptr] <= wdata;
        end
    end

endmodule

// ==== axi_bus/axi_bus.sv ====
`timescale 1ns/100ps
`include "axi_bus_cfg.svh"

module axi_bus (
    input  logic clk_i,
    input  logic rst_ni,
    // CPU master
    input  axi_bus_pkg::bus_id_t       cpu_awid, cpu_arid,
    input  logic [`ADDR_WIDTH-1:0]     cpu_awaddr, cpu_araddr,
    input  logic [`LEN_BITS-1:0]       cpu_awlen, cpu_arlen,
    input  logic [`DATA_WIDTH-1:0]     cpu_wdata,
    input  logic [`DATA_WIDTH/8-1:0]   cpu_wstrb,
    input  logic cpu_awvalid, cpu_wvalid, cpu_wlast, cpu_bready, cpu_arvalid, cpu_rready,
    output logic cpu_awready, cpu_wready, cpu_bvalid, cpu_arready, cpu_rvalid, cpu_rlast,
    output axi_bus_pkg::bus_id_t       cpu_bid, cpu_rid,
    output axi_bus_pkg::resp_t         cpu_bresp, cpu_rresp,
    output logic [`DATA_WIDTH-1:0]     cpu_rdata,
    // DMA master
    input  axi_bus_pkg::bus_id_t       dma_awid, dma_arid,
    input  logic [`ADDR_WIDTH-1:0]     dma_awaddr, dma_araddr,
    input  logic [`LEN_BITS-1:0]       dma_awlen, dma_arlen,
    input  logic [`DATA_WIDTH-1:0]     dma_wdata,
    input  logic [`DATA_WIDTH/8-1:0]   dma_wstrb,
    input  logic dma_awvalid, dma_wvalid, dma_wlast, dma_bready, dma_arvalid, dma_rready,
    output logic dma_awready, dma_wready, dma_bvalid, dma_arready, dma_rvalid, dma_rlast,
    output axi_bus_pkg::bus_id_t       dma_bid, dma_rid,
    output axi_bus_pkg::resp_t         dma_bresp, dma_rresp,
    output logic [`DATA_WIDTH-1:0]     dma_rdata,
    // Main memory slave
    output axi_bus_pkg::bus_id_t       mem_awid, mem_arid,
    output logic [`ADDR_WIDTH-1:0]     mem_awaddr, mem_araddr,
    output logic [`LEN_BITS-1:0]       mem_awlen, mem_arlen,
    output logic [`DATA_WIDTH-1:0]     mem_wdata,
    output logic [`DATA_WIDTH/8-1:0]   mem_wstrb,
    output logic mem_awvalid, mem_wvalid, mem_wlast, mem_bready, mem_arvalid, mem_rready,
    input  logic mem_awready, mem_wready, mem_bvalid, mem_arready, mem_rvalid, mem_rlast,
    input  axi_bus_pkg::bus_id_t       mem_bid, mem_rid,
    input  axi_bus_pkg::resp_t         mem_bresp, mem_rresp,
    input  logic [`DATA_WIDTH-1:0]     mem_rdata,
    // Scratch memory slave
    output axi_bus_pkg::bus_id_t       scr_awid, scr_arid,
    output logic [`ADDR_WIDTH-1:0]     scr_awaddr, scr_araddr,
    output logic [`LEN_BITS-1:0]       scr_awlen, scr_arlen,
    output logic [`DATA_WIDTH-1:0]     scr_wdata,
    output logic [`DATA_WIDTH/8-1:0]   scr_wstrb,
    output logic scr_awvalid, scr_wvalid, scr_wlast, scr_bready, scr_arvalid, scr_rready,
    input  logic scr_awready, scr_wready, scr_bvalid, scr_arready, scr_rvalid, scr_rlast,
    input  axi_bus_pkg::bus_id_t       scr_bid, scr_rid,
    input  axi_bus_pkg::resp_t         scr_bresp, scr_rresp,
    input  logic [`DATA_WIDTH-1:0]     scr_rdata
);
    import axi_bus_pkg::*;

    bus_id_t aw_id, ar_id, w_head, b_id, r_id;
    resp_t   b_resp, r_resp;
    logic    aw_valid, aw_ready, aw_to_scr, aw_hs;
    logic    ar_valid, ar_ready, ar_to_scr;
    logic    w_valid, w_ready, w_last, w_to_scr, w_from_dma, w_done;
    logic    b_valid, b_ready, b_to_dma;
    logic    r_valid, r_ready, r_last, r_to_dma;
    logic    route_full, route_empty;
    logic [`DATA_WIDTH-1:0]   w_data, r_data;
    logic [`DATA_WIDTH/8-1:0] w_strb;

    // DMA always wins the request channels
    assign aw_id     = dma_awvalid ? dma_awid : cpu_awid;
    assign aw_valid  = dma_awvalid || cpu_awvalid;
    assign aw_to_scr = id_to_scr(aw_id);
    assign aw_ready  = (aw_to_scr ? scr_awready : mem_awready) && !route_full;
    assign aw_hs     = aw_valid && aw_ready;

    assign mem_awid    = aw_id;
    assign scr_awid    = aw_id;
    assign mem_awaddr  = dma_awvalid ? dma_awaddr : cpu_awaddr;
    assign scr_awaddr  = mem_awaddr;
    assign mem_awlen   = dma_awvalid ? dma_awlen : cpu_awlen;
    assign scr_awlen   = mem_awlen;
    assign mem_awvalid = aw_valid && !aw_to_scr && !route_full;
    assign scr_awvalid = aw_valid && aw_to_scr && !route_full;
    assign cpu_awready = aw_ready && !dma_awvalid;
    assign dma_awready = aw_ready && dma_awvalid;

    // W beats follow AW order through the route queue
    fifo #(.DEPTH(`ROUTE_DEPTH)) i_route_fifo (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .push   (aw_hs),
        .pop    (w_done),
        .wdata  (aw_id),
        .rdata  (w_head),
        .full   (route_full),
        .empty  (route_empty)
    );

    assign w_from_dma = id_from_dma(w_head);
    assign w_to_scr   = id_to_scr(w_head);
    assign w_valid    = !route_empty && (w_from_dma ? dma_wvalid : cpu_wvalid);
    assign w_data     = w_from_dma ? dma_wdata : cpu_wdata;
    assign w_strb     = w_from_dma ? dma_wstrb : cpu_wstrb;
    assign w_last     = w_from_dma ? dma_wlast : cpu_wlast;
    assign w_ready    = !route_empty && (w_to_scr ? scr_wready : mem_wready);
    assign w_done     = w_valid && w_ready && w_last;

    assign mem_wdata  = w_data;
    assign scr_wdata  = w_data;
    assign mem_wstrb  = w_strb;
    assign scr_wstrb  = w_strb;
    assign mem_wlast  = w_last;
    assign scr_wlast  = w_last;
    assign mem_wvalid = w_valid && !w_to_scr;
    assign scr_wvalid = w_valid && w_to_scr;
    assign cpu_wready = w_ready && !w_from_dma;
    assign dma_wready = w_ready && w_from_dma;

    assign ar_id     = dma_arvalid ? dma_arid : cpu_arid;
    assign ar_valid  = dma_arvalid || cpu_arvalid;
    assign ar_to_scr = id_to_scr(ar_id);
    assign ar_ready  = ar_to_scr ? scr_arready : mem_arready;

    assign mem_arid    = ar_id;
    assign scr_arid    = ar_id;
    assign mem_araddr  = dma_arvalid ? dma_araddr : cpu_araddr;
    assign scr_araddr  = mem_araddr;
    assign mem_arlen   = dma_arvalid ? dma_arlen : cpu_arlen;
    assign scr_arlen   = mem_arlen;
    assign mem_arvalid = ar_valid && !ar_to_scr;
    assign scr_arvalid = ar_valid && ar_to_scr;
    assign cpu_arready = ar_ready && !dma_arvalid;
    assign dma_arready = ar_ready && dma_arvalid;

    // Responses, main memory first
    assign b_id       = mem_bvalid ? mem_bid : scr_bid;
    assign b_resp     = mem_bvalid ? mem_bresp : scr_bresp;
    assign b_valid    = mem_bvalid || scr_bvalid;
    assign b_to_dma   = id_from_dma(b_id);
    assign b_ready    = b_to_dma ? dma_bready : cpu_bready;
    assign mem_bready = b_ready && mem_bvalid;
    assign scr_bready = b_ready && !mem_bvalid;
    assign cpu_bid    = b_id;
    assign dma_bid    = b_id;
    assign cpu_bresp  = b_resp;
    assign dma_bresp  = b_resp;
    assign cpu_bvalid = b_valid && !b_to_dma;
    assign dma_bvalid = b_valid && b_to_dma;

    assign r_id       = mem_rvalid ? mem_rid : scr_rid;
    assign r_data     = mem_rvalid ? mem_rdata : scr_rdata;
    assign r_resp     = mem_rvalid ? mem_rresp : scr_rresp;
    assign r_last     = mem_rvalid ? mem_rlast : scr_rlast;
    assign r_valid    = mem_rvalid || scr_rvalid;
    assign r_to_dma   = id_from_dma(r_id);
    assign r_ready    = r_to_dma ? dma_rready : cpu_rready;
    assign mem_rready = r_ready && mem_rvalid;
    assign scr_rready = r_ready && !mem_rvalid;
    assign cpu_rid    = r_id;
    assign dma_rid    = r_id;
    assign cpu_rdata  = r_data;
    assign dma_rdata  = r_data;
    assign cpu_rresp  = r_resp;
    assign dma_rresp  = r_resp;
    assign cpu_rlast  = r_last;
    assign dma_rlast  = r_last;
    assign cpu_rvalid = r_valid && !r_to_dma;
    assign dma_rvalid = r_valid && r_to_dma;

endmodule

// ==== source/axi_mem_slave.sv ====
`timescale 1ns/100ps
`include "axi_bus_cfg.svh"

module axi_mem_slave #(
    parameter int DEPTH = 64
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  axi_bus_pkg::bus_id_t     awid, arid,
    input  logic [`ADDR_WIDTH-1:0]   awaddr, araddr,
    input  logic [`LEN_BITS-1:0]     awlen, arlen,
    input  logic [`DATA_WIDTH-1:0]   wdata,
    input  logic [`DATA_WIDTH/8-1:0] wstrb,
    input  logic                     awvalid, wvalid, wlast, bready, arvalid, rready,
    output logic                     awready, wready, bvalid, arready, rvalid, rlast,
    output axi_bus_pkg::bus_id_t     bid, rid,
    output axi_bus_pkg::resp_t       bresp, rresp,
    output logic [`DATA_WIDTH-1:0]   rdata
);
    import axi_bus_pkg::*;

    localparam int BYTES  = `DATA_WIDTH / 8;
    localparam int WORD_W = `ADDR_WIDTH - $clog2(BYTES);
    localparam int IDX_W  = $clog2(DEPTH);

    typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} w_state_t;
    typedef enum logic {R_IDLE, R_DATA} r_state_t;

    logic [`DATA_WIDTH-1:0] mem [DEPTH];
    w_state_t              w_state;
    r_state_t              r_state;
    bus_id_t               w_id, r_id;
    // One extra bit so a burst near the top of the map cannot wrap back in range
    logic [WORD_W:0]       w_addr, r_addr;
    logic [`LEN_BITS-1:0]  w_cnt, r_cnt;
    logic                  w_err, w_in_range, r_in_range;
    logic                  aw_hs, w_hs, ar_hs, r_hs;

    assign awready    = (w_state == W_IDLE);
    assign wready     = (w_state == W_DATA);
    assign bvalid     = (w_state == W_RESP);
    assign bid        = w_id;
    assign bresp      = w_err ? RESP_SLVERR : RESP_OKAY;
    assign aw_hs      = awvalid && awready;
    assign w_hs       = wvalid && wready;
    assign w_in_range = (w_addr < DEPTH);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            w_state <= W_IDLE;
            w_err   <= 1'b0;
        end else begin
            case (w_state)
                W_IDLE: if (aw_hs) begin
                    w_state <= W_DATA;
                    w_err   <= 1'b0;
                end
                W_DATA: if (w_hs) begin
                    // Out of range, or wlast not on beat len+1
                    w_err <= w_err || !w_in_range || (wlast != (w_cnt == '0));
                    if (wlast) begin
                        w_state <= W_RESP;
                    end
                end
                W_RESP: if (bready) begin
                    w_state <= W_IDLE;
                end
                default: w_state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_hs) begin
            w_id   <= awid;
            w_addr <= {1'b0, awaddr[`ADDR_WIDTH-1:`ADDR_WIDTH-WORD_W]};
            w_cnt  <= awlen;
        end else if (w_hs) begin
            w_addr <= w_addr + 1'b1;
            w_cnt  <= w_cnt - 1'b1;
        end
    end

    // Strobed byte writes
    always_ff @(posedge clk_i) begin
        if (w_hs && w_in_range) begin
            for (int b = 0; b < BYTES; b++) begin
                if (wstrb[b]) begin
                    mem[w_addr[IDX_W-1:0]][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    assign arready    = (r_state == R_IDLE);
    assign rvalid     = (r_state == R_DATA);
    assign rlast      = (r_cnt == '0);
    assign rid        = r_id;
    assign r_in_range = (r_addr < DEPTH);
    assign rdata      = r_in_range ? mem[r_addr[IDX_W-1:0]] : '0;
    assign rresp      = r_in_range ? RESP_OKAY : RESP_SLVERR;
    assign ar_hs      = arvalid && arready;
    assign r_hs       = rvalid && rready;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            r_state <= R_IDLE;
        end else if (ar_hs) begin
            r_state <= R_DATA;
        end else if (r_hs && rlast) begin
            r_state <= R_IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ar_hs) begin
            r_id   <= arid;
            r_addr <= {1'b0, araddr[`ADDR_WIDTH-1:`ADDR_WIDTH-WORD_W]};
            r_cnt  <= arlen;
        end else if (r_hs) begin
            r_addr <= r_addr + 1'b1;
            r_cnt  <= r_cnt - 1'b1;
        end
    end

endmodule

// ==== source/axi_subsystem.sv ====
`timescale 1ns/100ps
`include "axi_bus_cfg.svh"

module axi_subsystem (
    input  logic clk_i,
    input  logic rst_ni,
    // CPU master
    input  axi_bus_pkg::bus_id_t       cpu_awid, cpu_arid,
    input  logic [`ADDR_WIDTH-1:0]     cpu_awaddr, cpu_araddr,
    input  logic [`LEN_BITS-1:0]       cpu_awlen, cpu_arlen,
    input  logic [`DATA_WIDTH-1:0]     cpu_wdata,
    input  logic [`DATA_WIDTH/8-1:0]   cpu_wstrb,
    input  logic cpu_awvalid, cpu_wvalid, cpu_wlast, cpu_bready, cpu_arvalid, cpu_rready,
    output logic cpu_awready, cpu_wready, cpu_bvalid, cpu_arready, cpu_rvalid, cpu_rlast,
    output axi_bus_pkg::bus_id_t       cpu_bid, cpu_rid,
    output axi_bus_pkg::resp_t         cpu_bresp, cpu_rresp,
    output logic [`DATA_WIDTH-1:0]     cpu_rdata,
    // DMA master
    input  axi_bus_pkg::bus_id_t       dma_awid, dma_arid,
    input  logic [`ADDR_WIDTH-1:0]     dma_awaddr, dma_araddr,
    input  logic [`LEN_BITS-1:0]       dma_awlen, dma_arlen,
    input  logic [`DATA_WIDTH-1:0]     dma_wdata,
    input  logic [`DATA_WIDTH/8-1:0]   dma_wstrb,
    input  logic dma_awvalid, dma_wvalid, dma_wlast, dma_bready, dma_arvalid, dma_rready,
    output logic dma_awready, dma_wready, dma_bvalid, dma_arready, dma_rvalid, dma_rlast,
    output axi_bus_pkg::bus_id_t       dma_bid, dma_rid,
    output axi_bus_pkg::resp_t         dma_bresp, dma_rresp,
    output logic [`DATA_WIDTH-1:0]     dma_rdata
);
    import axi_bus_pkg::*;

    // Main memory side
    bus_id_t                  mem_awid, mem_arid, mem_bid, mem_rid;
    resp_t                    mem_bresp, mem_rresp;
    logic [`ADDR_WIDTH-1:0]   mem_awaddr, mem_araddr;
    logic [`LEN_BITS-1:0]     mem_awlen, mem_arlen;
    logic [`DATA_WIDTH-1:0]   mem_wdata, mem_rdata;
    logic [`DATA_WIDTH/8-1:0] mem_wstrb;
    logic mem_awvalid, mem_wvalid, mem_wlast, mem_bready, mem_arvalid, mem_rready;
    logic mem_awready, mem_wready, mem_bvalid, mem_arready, mem_rvalid, mem_rlast;

    // Scratch side
    bus_id_t                  scr_awid, scr_arid, scr_bid, scr_rid;
    resp_t                    scr_bresp, scr_rresp;
    logic [`ADDR_WIDTH-1:0]   scr_awaddr, scr_araddr;
    logic [`LEN_BITS-1:0]     scr_awlen, scr_arlen;
    logic [`DATA_WIDTH-1:0]   scr_wdata, scr_rdata;
    logic [`DATA_WIDTH/8-1:0] scr_wstrb;
    logic scr_awvalid, scr_wvalid, scr_wlast, scr_bready, scr_arvalid, scr_rready;
    logic scr_awready, scr_wready, scr_bvalid, scr_arready, scr_rvalid, scr_rlast;

    // Port names of the bus match the signals here one to one
    axi_bus i_bus (.*);

    axi_mem_slave #(.DEPTH(`MEM_DEPTH)) i_mem (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .awid    (mem_awid), .awaddr(mem_awaddr), .awlen(mem_awlen),
        .awvalid (mem_awvalid), .awready(mem_awready),
        .wdata   (mem_wdata), .wstrb(mem_wstrb), .wlast(mem_wlast),
        .wvalid  (mem_wvalid), .wready(mem_wready),
        .bid     (mem_bid), .bresp(mem_bresp), .bvalid(mem_bvalid), .bready(mem_bready),
        .arid    (mem_arid), .araddr(mem_araddr), .arlen(mem_arlen),
        .arvalid (mem_arvalid), .arready(mem_arready),
        .rid     (mem_rid), .rdata(mem_rdata), .rresp(mem_rresp), .rlast(mem_rlast),
        .rvalid  (mem_rvalid), .rready(mem_rready)
    );

    axi_mem_slave #(.DEPTH(`SCR_DEPTH)) i_scr (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .awid    (scr_awid), .awaddr(scr_awaddr), .awlen(scr_awlen),
        .awvalid (scr_awvalid), .awready(scr_awready),
        .wdata   (scr_wdata), .wstrb(scr_wstrb), .wlast(scr_wlast),
        .wvalid  (scr_wvalid), .wready(scr_wready),
        .bid     (scr_bid), .bresp(scr_bresp), .bvalid(scr_bvalid), .bready(scr_bready),
        .arid    (scr_arid), .araddr(scr_araddr), .arlen(scr_arlen),
        .arvalid (scr_arvalid), .arready(scr_arready),
        .rid     (scr_rid), .rdata(scr_rdata), .rresp(scr_rresp), .rlast(scr_rlast),
        .rvalid  (scr_rvalid), .rready(scr_rready)
    );

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release just after an edge, like the rest of the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

// ==== tb/tb_axi_subsystem.sv ====
`timescale 1ns/100ps
`include "axi_bus_cfg.svh"

module tb_axi_subsystem;
    import axi_bus_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int RANDOM_OPS      = 60;
    localparam int WATCHDOG_CYCLES = RANDOM_OPS * 200;
    localparam int MAX_BEATS       = 1 << `LEN_BITS;
    localparam int STRB_W          = `DATA_WIDTH / 8;

    logic clk_i;
    logic rst_ni;

    // Index 0 is the CPU master, index 1 the DMA master
    bus_id_t                awid [2];
    bus_id_t                arid [2];
    logic [`ADDR_WIDTH-1:0] awaddr [2];
    logic [`ADDR_WIDTH-1:0] araddr [2];
    logic [`LEN_BITS-1:0]   awlen [2];
    logic [`LEN_BITS-1:0]   arlen [2];
    logic [`DATA_WIDTH-1:0] wdata [2];
    logic [STRB_W-1:0]      wstrb [2];
    logic [1:0]             awvalid, wvalid, wlast, bready, arvalid, rready;
    wire  [1:0]             awready, wready, bvalid, arready, rvalid, rlast;
    wire  [`ID_BITS-1:0]    bid [2];
    wire  [`ID_BITS-1:0]    rid [2];
    wire  [1:0]             bresp [2];
    wire  [1:0]             rresp [2];
    wire  [`DATA_WIDTH-1:0] rdata [2];

    // Reference model of both memories
    logic [`DATA_WIDTH-1:0] ref_mem [`MEM_DEPTH];
    logic [`DATA_WIDTH-1:0] ref_scr [`SCR_DEPTH];

    // Burst in flight per master
    bus_id_t                wr_id [2];
    int                     wr_word [2];
    int                     wr_len [2];
    logic [`DATA_WIDTH-1:0] wr_data [2][MAX_BEATS];
    logic [STRB_W-1:0]      wr_strb [2][MAX_BEATS];
    logic [1:0]             wr_pend;
    bus_id_t                rd_id [2];
    int                     rd_word [2];
    int                     rd_len [2];
    int                     rd_beat [2];
    logic [1:0]             rd_pend;
    time                    aw_time [2];

    int   seed;
    int   ready_seed;
    logic stall_en;
    int   checks;
    int   errors;

    tb_clk_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(3)) i_clk_gen (
        .clk   (clk_i),
        .rst_n (rst_ni)
    );

    axi_subsystem i_axi_subsystem (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .cpu_awid(awid[0]), .cpu_awaddr(awaddr[0]), .cpu_awlen(awlen[0]),
        .cpu_awvalid(awvalid[0]), .cpu_awready(awready[0]),
        .cpu_wdata(wdata[0]), .cpu_wstrb(wstrb[0]), .cpu_wlast(wlast[0]),
        .cpu_wvalid(wvalid[0]), .cpu_wready(wready[0]),
        .cpu_bid(bid[0]), .cpu_bresp(bresp[0]), .cpu_bvalid(bvalid[0]), .cpu_bready(bready[0]),
        .cpu_arid(arid[0]), .cpu_araddr(araddr[0]), .cpu_arlen(arlen[0]),
        .cpu_arvalid(arvalid[0]), .cpu_arready(arready[0]),
        .cpu_rid(rid[0]), .cpu_rdata(rdata[0]), .cpu_rresp(rresp[0]), .cpu_rlast(rlast[0]),
        .cpu_rvalid(rvalid[0]), .cpu_rready(rready[0]),
        .dma_awid(awid[1]), .dma_awaddr(awaddr[1]), .dma_awlen(awlen[1]),
        .dma_awvalid(awvalid[1]), .dma_awready(awready[1]),
        .dma_wdata(wdata[1]), .dma_wstrb(wstrb[1]), .dma_wlast(wlast[1]),
        .dma_wvalid(wvalid[1]), .dma_wready(wready[1]),
        .dma_bid(bid[1]), .dma_bresp(bresp[1]), .dma_bvalid(bvalid[1]), .dma_bready(bready[1]),
        .dma_arid(arid[1]), .dma_araddr(araddr[1]), .dma_arlen(arlen[1]),
        .dma_arvalid(arvalid[1]), .dma_arready(arready[1]),
        .dma_rid(rid[1]), .dma_rdata(rdata[1]), .dma_rresp(rresp[1]), .dma_rlast(rlast[1]),
        .dma_rvalid(rvalid[1]), .dma_rready(rready[1])
    );

    // Low ID bit selects the scratch memory
    function automatic int depth_of(input bus_id_t id);
        return id[0] ? `SCR_DEPTH : `MEM_DEPTH;
    endfunction

    function automatic resp_t apply_write(input int m);
        resp_t resp;
        int    w;
        resp = RESP_OKAY;
        for (int i = 0; i <= wr_len[m]; i++) begin
            w = wr_word[m] + i;
            if (w >= depth_of(wr_id[m])) begin
                resp = RESP_SLVERR;
            end else begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (wr_strb[m][i][b] && wr_id[m][0]) begin
                        ref_scr[w][b*8 +: 8] = wr_data[m][i][b*8 +: 8];
                    end else if (wr_strb[m][i][b]) begin
                        ref_mem[w][b*8 +: 8] = wr_data[m][i][b*8 +: 8];
                    end
                end
            end
        end
        return resp;
    endfunction

    function automatic resp_t expect_read(input bus_id_t id, input int w,
                                          output logic [`DATA_WIDTH-1:0] data);
        if (w >= depth_of(id)) begin
            data = '0;
            return RESP_SLVERR;
        end
        data = id[0] ? ref_scr[w] : ref_mem[w];
        return RESP_OKAY;
    endfunction

    task automatic log_mismatch(input string msg);
        errors++;
        $display("error @ %0t ns: %s", $time, msg);
    endtask

    task automatic count_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic check_port(input int m);
        logic [`DATA_WIDTH-1:0] exp_data;
        resp_t                  exp_resp;
        assert (!bvalid[m] || wr_pend[m]) else
            count_failure($sformatf("Write response on the %s port with no write pending",
                                    m ? "DMA" : "CPU"));
        if (bvalid[m] && bready[m] && wr_pend[m]) begin
            exp_resp = apply_write(m);
            checks++;
            assert (bresp[m] === exp_resp && bid[m] === wr_id[m]) else
                log_mismatch($sformatf("port %0d bid %0d bresp %0d, expected %0d and %0d",
                                       m, bid[m], bresp[m], wr_id[m], exp_resp));
            wr_pend[m] = 1'b0;
        end
        assert (!rvalid[m] || rd_pend[m]) else
            count_failure($sformatf("Read data on the %s port with no read pending",
                                    m ? "DMA" : "CPU"));
        if (rvalid[m] && rready[m] && rd_pend[m]) begin
            exp_resp = expect_read(rd_id[m], rd_word[m] + rd_beat[m], exp_data);
            checks++;
            assert (rdata[m] === exp_data && rresp[m] === exp_resp && rid[m] === rd_id[m]
                    && rlast[m] === (rd_beat[m] == rd_len[m])) else
                log_mismatch($sformatf("port %0d beat %0d rdata %h rresp %0d rlast %b, exp %h %0d",
                                       m, rd_beat[m], rdata[m], rresp[m], rlast[m],
                                       exp_data, exp_resp));
            if (rd_beat[m] == rd_len[m]) begin
                rd_pend[m] = 1'b0;
            end else begin
                rd_beat[m]++;
            end
        end
    endtask

    always @(posedge clk_i) begin
        if (rst_ni) begin
            check_port(0);
            check_port(1);
        end
    end

    // Random back-pressure on B and R
    always @(posedge clk_i) begin
        #2;
        if (stall_en) begin
            bready = 2'($random(ready_seed));
            rready = 2'($random(ready_seed));
        end else begin
            bready = 2'b11;
            rready = 2'b11;
        end
    end

    task automatic make_burst(input int m, input int len, input logic rand_strb);
        for (int i = 0; i <= len; i++) begin
            wr_data[m][i] = $random(seed);
            wr_strb[m][i] = rand_strb ? STRB_W'($random(seed)) : '1;
        end
    endtask

    task automatic write_burst(input int m, input bus_id_t id, input int word, input int len);
        wr_id[m]   = id;
        wr_word[m] = word;
        wr_len[m]  = len;
        wr_pend[m] = 1'b1;
        awid[m]    = id;
        awaddr[m]  = `ADDR_WIDTH'(word * STRB_W);
        awlen[m]   = `LEN_BITS'(len);
        awvalid[m] = 1'b1;
        do @(posedge clk_i); while (!awready[m]);
        aw_time[m] = $time;
        #2;
        awvalid[m] = 1'b0;
        for (int i = 0; i <= len; i++) begin
            wdata[m]  = wr_data[m][i];
            wstrb[m]  = wr_strb[m][i];
            wlast[m]  = (i == len);
            wvalid[m] = 1'b1;
            do @(posedge clk_i); while (!wready[m]);
            #2;
        end
        wvalid[m] = 1'b0;
        wlast[m]  = 1'b0;
        do @(posedge clk_i); while (!(bvalid[m] && bready[m]));
        #2;
    endtask

    task automatic read_burst(input int m, input bus_id_t id, input int word, input int len);
        int beats;
        rd_id[m]   = id;
        rd_word[m] = word;
        rd_len[m]  = len;
        rd_beat[m] = 0;
        rd_pend[m] = 1'b1;
        arid[m]    = id;
        araddr[m]  = `ADDR_WIDTH'(word * STRB_W);
        arlen[m]   = `LEN_BITS'(len);
        arvalid[m] = 1'b1;
        do @(posedge clk_i); while (!arready[m]);
        #2;
        arvalid[m] = 1'b0;
        beats = 0;
        while (beats <= len) begin
            @(posedge clk_i);
            if (rvalid[m] && rready[m]) begin
                beats++;
            end
        end
        #2;
    endtask

    // Each master keeps to its own half of each memory
    task automatic random_op(input int m);
        logic    to_scr;
        bus_id_t id;
        int      size;
        int      len;
        int      word;
        to_scr = $random(seed) & 1;
        id     = bus_id_t'({m[0], to_scr});
        size   = to_scr ? `SCR_DEPTH / 2 : `MEM_DEPTH / 2;
        len    = $unsigned($random(seed)) % ((size < MAX_BEATS) ? size : MAX_BEATS);
        word   = m * size + $unsigned($random(seed)) % (size - len);
        if ($random(seed) & 1) begin
            make_burst(m, len, 1'b1);
            write_burst(m, id, word, len);
        end else begin
            read_burst(m, id, word, len);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, %0d checks done, %0d errors",
                 WATCHDOG_CYCLES, checks, errors);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        seed       = 3826;
        ready_seed = seed;
        stall_en   = 1'b0;
        checks     = 0;
        errors     = 0;
        wr_pend    = '0;
        rd_pend    = '0;
        awvalid    = '0;
        wvalid     = '0;
        wlast      = '0;
        arvalid    = '0;
        bready     = '1;
        rready     = '1;
        for (int m = 0; m < 2; m++) begin
            awid[m]   = ID_CPU2MEM;
            arid[m]   = ID_CPU2MEM;
            awaddr[m] = '0;
            araddr[m] = '0;
            awlen[m]  = '0;
            arlen[m]  = '0;
            wdata[m]  = '0;
            wstrb[m]  = '0;
        end
        wait (rst_ni);
        @(posedge clk_i);
        #2;

        // Known contents everywhere before any read
        for (int w = 0; w < `MEM_DEPTH; w += MAX_BEATS) begin
            make_burst(0, MAX_BEATS - 1, 1'b0);
            write_burst(0, ID_CPU2MEM, w, MAX_BEATS - 1);
        end
        make_burst(1, `SCR_DEPTH - 1, 1'b0);
        write_burst(1, ID_DMA2SCR, 0, `SCR_DEPTH - 1);

        make_burst(0, 3, 1'b0);
        write_burst(0, ID_CPU2MEM, 4, 3);
        read_burst(0, ID_CPU2MEM, 4, 3);

        // DMA to scratch, CPU ports must stay quiet
        make_burst(1, 3, 1'b0);
        write_burst(1, ID_DMA2SCR, 2, 3);
        make_burst(1, 7, 1'b0);
        write_burst(1, ID_DMA2SCR, 8, 7);
        read_burst(1, ID_DMA2SCR, 0, `SCR_DEPTH - 1);

        // Same cycle AW from both masters on the same words
        make_burst(0, 3, 1'b0);
        make_burst(1, 3, 1'b0);
        fork
            write_burst(0, ID_CPU2MEM, 40, 3);
            write_burst(1, ID_DMA2MEM, 40, 3);
        join
        checks++;
        assert (aw_time[1] < aw_time[0]) else
            count_failure("The CPU write was accepted before the DMA write");
        read_burst(0, ID_CPU2MEM, 40, 3);

        // Partial strobes
        make_burst(0, 3, 1'b0);
        wr_strb[0][0] = 4'b0101;
        wr_strb[0][1] = 4'b1000;
        wr_strb[0][2] = 4'b0000;
        wr_strb[0][3] = 4'b1110;
        write_burst(0, ID_CPU2MEM, 20, 3);
        read_burst(0, ID_CPU2MEM, 20, 3);

        // Last four beats fall past the end of scratch
        make_burst(0, 7, 1'b0);
        write_burst(0, ID_CPU2SCR, `SCR_DEPTH - 4, 7);
        read_burst(0, ID_CPU2SCR, `SCR_DEPTH - 4, 7);

        stall_en = 1'b1;
        fork
            repeat (RANDOM_OPS / 2) random_op(0);
            repeat (RANDOM_OPS / 2) random_op(1);
        join
        stall_en = 1'b0;
        repeat (4) @(posedge clk_i);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== axi_subsystem.f ====
+incdir+common
common/axi_bus_pkg.sv
source/fifo.sv
axi_bus/axi_bus.sv
source/axi_mem_slave.sv
source/axi_subsystem.sv
tb/tb_clk_gen.sv
tb/tb_axi_subsystem.sv
